// File: hdl/soc_consts.svh
// SoC bus constants
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Lanes and data path
`define SOC_NR_LANES   4
`define SOC_DATA_W     (32 * `SOC_NR_LANES)
`define SOC_STRB_W     (`SOC_DATA_W / 8)
`define SOC_ADDR_W     32
`define SOC_APB_W      32

// L2 depth in wide words
`define SOC_L2_WORDS   1024
`define SOC_L2_IDX_W   10

// Memory map
`define SOC_DRAM_BASE  32'h8000_0000
`define SOC_DRAM_LEN   32'h4000_0000
`define SOC_UART_BASE  32'hC000_0000
`define SOC_CTRL_BASE  32'hD000_0000
`define SOC_PERIPH_LEN 32'h0000_1000

`endif

// File: hdl/soc_pkg.sv
// SoC bus types
`include "soc_consts.svh"

package soc_pkg;

  // Target of an accepted request
  typedef enum logic [1:0] {
    REGION_L2,
    REGION_UART,
    REGION_CTRL,
    REGION_NONE
  } soc_region_e;

  // Address as seen by the L2 banks
  typedef struct packed {
    logic [3:0]                                                     tag;
    logic [`SOC_ADDR_W-`SOC_L2_IDX_W-$clog2(`SOC_STRB_W)-5:0]       unused;
    logic [`SOC_L2_IDX_W-1:0]                                       idx;
    logic [$clog2(`SOC_STRB_W)-1:0]                                 offset;
  } soc_mem_addr_t;

  // Address as seen by the peripherals
  // Lane select spans bits 3 to 2, its upper bit shared with reg_idx
  typedef struct packed {
    logic [3:0]               tag;
    logic [`SOC_ADDR_W-11:0]  unused;
    logic [2:0]               reg_idx;
    logic                     lane_lsb;
    logic [1:0]               byte_sel;
  } soc_periph_addr_t;

  typedef union packed {
    soc_mem_addr_t    mem;
    soc_periph_addr_t periph;
  } soc_addr_u;

endpackage

// File: hdl/addr_router.sv
// Address decode and steering
`timescale 1ns/1ps
`include "soc_consts.svh"

module addr_router (
  input  logic                     req_i,
  input  logic                     we_i,
  input  soc_pkg::soc_addr_u       addr_i,
  input  logic                     uart_busy_i,
  output logic                     gnt_o,
  output logic [`SOC_NR_LANES-1:0] bank_en_o,
  output logic                     bank_we_o,
  output logic [`SOC_L2_IDX_W-1:0] bank_idx_o,
  output logic                     ctrl_wr_o,
  output logic                     ctrl_rd_o,
  output logic                     uart_start_o,
  output logic                     acc_o,
  output soc_pkg::soc_region_e     acc_region_o
);

  import soc_pkg::*;

  logic [`SOC_ADDR_W-1:0] addr;

  assign addr = addr_i;

  // Window match, offset from base must fall inside the length
  always_comb begin
    if (addr - `SOC_DRAM_BASE < `SOC_DRAM_LEN) begin
      acc_region_o = REGION_L2;
    end else if (addr - `SOC_UART_BASE < `SOC_PERIPH_LEN) begin
      acc_region_o = REGION_UART;
    end else if (addr - `SOC_CTRL_BASE < `SOC_PERIPH_LEN) begin
      acc_region_o = REGION_CTRL;
    end else begin
      acc_region_o = REGION_NONE;
    end
  end

  // Only a running APB transfer holds off the requester
  assign gnt_o = ~uart_busy_i;
  assign acc_o = req_i & gnt_o;

  ////////////////////
  // Target strobes
  ////////////////////

  assign bank_en_o  = {`SOC_NR_LANES{acc_o && acc_region_o == REGION_L2}};
  assign bank_we_o  = we_i;
  assign bank_idx_o = addr_i.mem.idx;

  assign ctrl_wr_o = acc_o && acc_region_o == REGION_CTRL && we_i;
  assign ctrl_rd_o = acc_o && acc_region_o == REGION_CTRL && !we_i;

  assign uart_start_o = acc_o && acc_region_o == REGION_UART;

endmodule

// File: hdl/l2_lane_bank.sv
// L2 lane bank
`timescale 1ns/1ps
`include "soc_consts.svh"

module l2_lane_bank #(
  parameter int unsigned lane_idx = 0
) (
  input  logic                     clk_i,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [`SOC_L2_IDX_W-1:0] idx_i,
  input  logic [`SOC_STRB_W-1:0]   be_i,
  input  logic [`SOC_DATA_W-1:0]   wdata_i,
  output logic [31:0]              rdata_o
);

  logic [31:0] mem [`SOC_L2_WORDS];

  // Read returns the word before this cycle's write
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[lane_idx*4 + b]) begin
            mem[idx_i][b*8 +: 8] <= wdata_i[lane_idx*32 + b*8 +: 8];
          end
        end
      end
      rdata_o <= mem[idx_i];
    end
  end

endmodule

// File: hdl/uart_apb_bridge.sv
// UART APB master
`timescale 1ns/1ps
`include "soc_consts.svh"

module uart_apb_bridge (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    start_i,
  input  logic                    we_i,
  input  soc_pkg::soc_addr_u      addr_i,
  input  logic [`SOC_DATA_W-1:0]  wdata_i,
  output logic                    busy_o,
  output logic                    done_o,
  output logic [`SOC_APB_W-1:0]   rdata_o,
  output logic                    uart_psel_o,
  output logic                    uart_penable_o,
  output logic                    uart_pwrite_o,
  output logic [`SOC_ADDR_W-1:0]  uart_paddr_o,
  output logic [`SOC_APB_W-1:0]   uart_pwdata_o,
  input  logic [`SOC_APB_W-1:0]   uart_prdata_i,
  input  logic                    uart_pready_i
);

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_SETUP  = 2'd1;
  localparam logic [1:0] ST_ACCESS = 2'd2;

  logic [1:0] state_q;
  logic [1:0] lane;
  logic       launch;
  logic       finish;

  // Lane of the wide word that carries the APB data
  assign lane   = {addr_i.periph.reg_idx[0], addr_i.periph.lane_lsb};
  assign launch = state_q == ST_IDLE && start_i;
  assign finish = state_q == ST_ACCESS && uart_pready_i;

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      done_o  <= 1'b0;
    end else begin
      done_o <= finish;
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q <= ST_SETUP;
          end
        end
        ST_SETUP: begin
          state_q <= ST_ACCESS;
        end
        ST_ACCESS: begin
          if (uart_pready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Request fields held for the whole transfer
  always_ff @(posedge clk_i) begin
    if (launch) begin
      uart_paddr_o  <= addr_i;
      uart_pwrite_o <= we_i;
      uart_pwdata_o <= wdata_i[lane*`SOC_APB_W +: `SOC_APB_W];
    end
    if (finish) begin
      rdata_o <= uart_prdata_i;
    end
  end

  assign busy_o         = state_q != ST_IDLE;
  assign uart_psel_o    = state_q != ST_IDLE;
  assign uart_penable_o = state_q == ST_ACCESS;

endmodule

// File: hdl/ctrl_regs.sv
// Control register block
`timescale 1ns/1ps
`include "soc_consts.svh"

module ctrl_regs (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               wr_i,
  input  logic               rd_i,
  input  soc_pkg::soc_addr_u addr_i,
  input  logic [7:0]         be_i,
  input  logic [63:0]        wdata_i,
  output logic [63:0]        rdata_o,
  output logic [63:0]        exit_o
);

  localparam logic [63:0] DRAM_BASE = 64'(`SOC_DRAM_BASE);
  localparam logic [63:0] DRAM_END  = 64'(`SOC_DRAM_BASE) + 64'(`SOC_DRAM_LEN);

  logic [2:0] reg_idx;

  assign reg_idx = addr_i.periph.reg_idx;

  ////////////////////
  // Exit register
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_o <= '0;
    end else if (wr_i && reg_idx == 3'd0) begin
      for (int b = 0; b < 8; b++) begin
        if (be_i[b]) begin
          exit_o[b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Registered read port
  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      case (reg_idx)
        3'd0:    rdata_o <= exit_o;
        3'd1:    rdata_o <= DRAM_BASE;
        3'd2:    rdata_o <= DRAM_END;
        default: rdata_o <= '0;
      endcase
    end
  end

endmodule

// File: hdl/resp_merge.sv
// Response merge
`timescale 1ns/1ps
`include "soc_consts.svh"

module resp_merge (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           acc_i,
  input  logic [1:0]                     region_i,
  input  logic [1:0]                     lane_i,
  input  logic [`SOC_NR_LANES-1:0][31:0] bank_rdata_i,
  input  logic [63:0]                    ctrl_rdata_i,
  input  logic                           uart_done_i,
  input  logic [`SOC_APB_W-1:0]          uart_rdata_i,
  output logic                           rvalid_o,
  output logic [`SOC_DATA_W-1:0]         rdata_o
);

  import soc_pkg::*;

  soc_region_e region;
  soc_region_e region_q;
  logic        valid_q;
  logic [1:0]  lane_q;

  assign region = soc_region_e'(region_i);

  // Fixed one-cycle response for everything but UART
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= acc_i && region != REGION_UART;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_i) begin
      region_q <= region;
    end
    // Lane kept until the APB transfer completes
    if (acc_i && region == REGION_UART) begin
      lane_q <= lane_i;
    end
  end

  assign rvalid_o = valid_q | uart_done_i;

  ////////////////////
  // Read data
  ////////////////////

  always_comb begin
    rdata_o = '0;
    if (uart_done_i) begin
      rdata_o[lane_q*`SOC_APB_W +: `SOC_APB_W] = uart_rdata_i;
    end else begin
      case (region_q)
        REGION_L2:   rdata_o = bank_rdata_i;
        REGION_CTRL: rdata_o[63:0] = ctrl_rdata_i;
        default:     rdata_o = '0;
      endcase
    end
  end

endmodule

// File: hdl/vec_soc.sv
// Vector SoC bus top
`timescale 1ns/1ps
`include "soc_consts.svh"

module vec_soc (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [`SOC_ADDR_W-1:0]  addr_i,
  input  logic [`SOC_STRB_W-1:0]  be_i,
  input  logic [`SOC_DATA_W-1:0]  wdata_i,
  output logic                    gnt_o,
  output logic                    rvalid_o,
  output logic [`SOC_DATA_W-1:0]  rdata_o,
  output logic [63:0]             exit_o,
  output logic                    uart_psel_o,
  output logic                    uart_penable_o,
  output logic                    uart_pwrite_o,
  output logic [31:0]             uart_paddr_o,
  output logic [31:0]             uart_pwdata_o,
  input  logic [31:0]             uart_prdata_i,
  input  logic                    uart_pready_i
);

  logic [`SOC_NR_LANES-1:0]       bank_en;
  logic                           bank_we;
  logic [`SOC_L2_IDX_W-1:0]       bank_idx;
  logic [`SOC_NR_LANES-1:0][31:0] bank_rdata;
  logic                           ctrl_wr;
  logic                           ctrl_rd;
  logic [63:0]                    ctrl_rdata;
  logic                           uart_start;
  logic                           uart_busy;
  logic                           uart_done;
  logic [`SOC_APB_W-1:0]          uart_rdata;
  logic                           acc;
  logic [1:0]                     acc_region;

  ////////////////////
  // Request routing
  ////////////////////

  addr_router i_router (
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .uart_busy_i (uart_busy),
    .gnt_o       (gnt_o),
    .bank_en_o   (bank_en),
    .bank_we_o   (bank_we),
    .bank_idx_o  (bank_idx),
    .ctrl_wr_o   (ctrl_wr),
    .ctrl_rd_o   (ctrl_rd),
    .uart_start_o(uart_start),
    .acc_o       (acc),
    .acc_region_o(acc_region)
  );

  ////////////////////
  // L2 lanes
  ////////////////////

  for (genvar g = 0; g < `SOC_NR_LANES; g++) begin : gen_lane
    l2_lane_bank #(
      .lane_idx(g)
    ) i_bank (
      .clk_i  (clk_i),
      .en_i   (bank_en[g]),
      .we_i   (bank_we),
      .idx_i  (bank_idx),
      .be_i   (be_i),
      .wdata_i(wdata_i),
      .rdata_o(bank_rdata[g])
    );
  end

  ////////////////////
  // Peripherals
  ////////////////////

  uart_apb_bridge i_uart (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .start_i       (uart_start),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .busy_o        (uart_busy),
    .done_o        (uart_done),
    .rdata_o       (uart_rdata),
    .uart_psel_o   (uart_psel_o),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o),
    .uart_paddr_o  (uart_paddr_o),
    .uart_pwdata_o (uart_pwdata_o),
    .uart_prdata_i (uart_prdata_i),
    .uart_pready_i (uart_pready_i)
  );

  ctrl_regs i_ctrl (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .wr_i   (ctrl_wr),
    .rd_i   (ctrl_rd),
    .addr_i (addr_i),
    .be_i   (be_i[7:0]),
    .wdata_i(wdata_i[63:0]),
    .rdata_o(ctrl_rdata),
    .exit_o (exit_o)
  );

  // Response path back to the requester
  resp_merge i_merge (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .acc_i       (acc),
    .region_i    (acc_region),
    .lane_i      (addr_i[3:2]),
    .bank_rdata_i(bank_rdata),
    .ctrl_rdata_i(ctrl_rdata),
    .uart_done_i (uart_done),
    .uart_rdata_i(uart_rdata),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o)
  );

endmodule

// File: dv/tb_vec_soc.sv
// Vector SoC bus testbench
`timescale 1ns/1ps
`include "soc_consts.svh"

module tb_vec_soc;

  localparam int L2_OPS = 8;
  // Worst-case cycles per test, summed, then doubled for the limit
  localparam int TEST_CYCLES = 6 + 3 * (L2_OPS + 2) + 12 + 4 * 10 + 10;
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

  logic         clk_i;
  logic         rst_i;
  logic         req_i;
  logic         we_i;
  logic [31:0]  addr_i;
  logic [15:0]  be_i;
  logic [127:0] wdata_i;
  logic         gnt_o;
  logic         rvalid_o;
  logic [127:0] rdata_o;
  logic [63:0]  exit_o;
  logic         uart_psel_o;
  logic         uart_penable_o;
  logic         uart_pwrite_o;
  logic [31:0]  uart_paddr_o;
  logic [31:0]  uart_pwdata_o;
  logic [31:0]  uart_prdata_i;
  logic         uart_pready_i;

  logic [127:0] l2_model [`SOC_L2_WORDS];
  logic [9:0]   idx_list [L2_OPS];
  logic [15:0]  lfsr;
  logic [31:0]  apb_last_addr;
  logic [31:0]  apb_last_data;
  int           value_errors;
  int           proto_errors;
  int           cycles;

  vec_soc uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [127:0] rand_wide();
    return {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
  endfunction

  // Only enabled bytes take the new data
  function automatic logic [127:0] merge_bytes(input logic [127:0] old_w,
                                               input logic [127:0] new_w,
                                               input logic [15:0] be);
    logic [127:0] r;
    r = old_w;
    for (int b = 0; b < 16; b++) begin
      if (be[b]) r[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] got);
    assert (got === exp) else begin
      $display("ERR %s exp=%h got=%h", name, exp, got);
      value_errors++;
    end
  endtask

  task automatic check_proto(input logic cond, input string what);
    assert (cond) else begin
      $display("Protocol error: %s", what);
      proto_errors++;
    end
  endtask

  task automatic drive(input logic we, input logic [31:0] addr,
                       input logic [15:0] be, input logic [127:0] wdata);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
  endtask

  // One request per cycle, each response checked a cycle after issue
  task automatic l2_burst(input logic write, input logic full_be);
    logic [127:0] exp_prev;
    logic         was_read;
    logic [15:0]  be;
    logic [127:0] data;
    exp_prev = '0;
    was_read = 1'b0;
    for (int k = 0; k <= L2_OPS; k++) begin
      @(negedge clk_i);
      if (k > 0) begin
        check_value("rvalid_o", 128'(1'b1), 128'(rvalid_o));
        if (was_read) check_value("rdata_o", exp_prev, rdata_o);
      end
      if (k < L2_OPS) begin
        check_proto(gnt_o, "grant low during L2 burst");
        be   = full_be ? 16'hffff : 16'(rand_bits(16));
        data = rand_wide();
        drive(write, `SOC_DRAM_BASE + {18'd0, idx_list[k], 4'd0}, be, data);
        if (write) begin
          l2_model[idx_list[k]] = merge_bytes(l2_model[idx_list[k]], data, be);
        end
        exp_prev = l2_model[idx_list[k]];
        was_read = !write;
      end else begin
        req_i = 1'b0;
      end
    end
  endtask

  task automatic single(input logic we, input logic [31:0] addr, input logic [15:0] be,
                        input logic [127:0] wdata, input logic [127:0] exp);
    @(negedge clk_i);
    check_value("rvalid_o", 128'(1'b0), 128'(rvalid_o));
    drive(we, addr, be, wdata);
    @(negedge clk_i);
    req_i = 1'b0;
    check_value("rvalid_o", 128'(1'b1), 128'(rvalid_o));
    if (!we) check_value("rdata_o", exp, rdata_o);
  endtask

  // Request plus APB slave model with random wait states
  task automatic uart_access(input logic we, input logic [1:0] lane);
    logic [31:0]  addr;
    logic [127:0] data;
    logic [31:0]  rd;
    int           waits;
    addr  = `SOC_UART_BASE + {26'd0, lane, 2'd0};
    data  = rand_wide();
    rd    = rand_bits(32);
    waits = int'(rand_bits(2));
    @(negedge clk_i);
    drive(we, addr, 16'hffff, data);
    @(negedge clk_i);
    req_i = 1'b0;
    check_proto(uart_psel_o && !uart_penable_o, "APB setup phase missing");
    check_proto(!gnt_o, "grant high during UART transfer");
    @(negedge clk_i);
    check_proto(uart_psel_o && uart_penable_o, "APB access phase missing");
    check_value("uart_paddr_o", 128'(addr), 128'(uart_paddr_o));
    check_value("uart_pwrite_o", 128'(we), 128'(uart_pwrite_o));
    if (we) check_value("uart_pwdata_o", 128'(data[lane*32 +: 32]), 128'(uart_pwdata_o));
    for (int w = 0; w < waits; w++) begin
      @(negedge clk_i);
      check_proto(uart_penable_o && !gnt_o && !rvalid_o, "access phase not held");
    end
    uart_pready_i = 1'b1;
    uart_prdata_i = rd;
    @(negedge clk_i);
    uart_pready_i = 1'b0;
    check_value("rvalid_o", 128'(1'b1), 128'(rvalid_o));
    check_proto(!uart_psel_o && !uart_penable_o && gnt_o, "APB transfer did not end");
    if (we) begin
      check_value("uart_paddr_o", 128'(addr), 128'(apb_last_addr));
      check_value("uart_pwdata_o", 128'(data[lane*32 +: 32]), 128'(apb_last_data));
    end else begin
      check_value("rdata_o", 128'(rd) << (lane * 32), rdata_o);
    end
  endtask

  // APB slave write log, taken on the completing edge
  always @(posedge clk_i) begin
    if (uart_psel_o && uart_penable_o && uart_pready_i && uart_pwrite_o) begin
      apb_last_addr <= uart_paddr_o;
      apb_last_data <= uart_pwdata_o;
    end
  end

  ////////////////////
  // Protocol checks
  ////////////////////

  assert property (@(posedge clk_i) disable iff (rst_i) uart_penable_o |-> uart_psel_o)
    else begin
      $display("Protocol error: uart_penable_o high without uart_psel_o");
      proto_errors++;
    end
  assert property (@(posedge clk_i) disable iff (rst_i) gnt_o == !uart_psel_o)
    else begin
      $display("Protocol error: gnt_o does not follow the APB transfer");
      proto_errors++;
    end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, a response never arrived", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    logic [63:0]  exit_exp;
    logic [7:0]   exit_be;
    logic [63:0]  exit_data;
    logic [127:0] fill;
    lfsr = 16'd35;
    value_errors = 0;
    proto_errors = 0;
    cycles = 0;
    rst_i = 1'b1;
    req_i = 1'b0;
    we_i = 1'b0;
    addr_i = '0;
    be_i = '0;
    wdata_i = '0;
    uart_prdata_i = '0;
    uart_pready_i = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    check_value("gnt_o", 128'(1'b1), 128'(gnt_o));
    check_value("rvalid_o", 128'(1'b0), 128'(rvalid_o));
    check_value("uart_psel_o", 128'(1'b0), 128'(uart_psel_o));
    check_value("uart_penable_o", 128'(1'b0), 128'(uart_penable_o));
    check_value("exit_o", 128'(0), 128'(exit_o));

    // L2: full fill, partial overwrite, read back
    for (int i = 0; i < L2_OPS; i++) idx_list[i] = 10'(rand_bits(10));
    l2_burst(1'b1, 1'b1);
    l2_burst(1'b1, 1'b0);
    l2_burst(1'b0, 1'b0);

    // Control registers
    single(1'b0, `SOC_CTRL_BASE + 32'h8, '0, '0, 128'h8000_0000);
    single(1'b0, `SOC_CTRL_BASE + 32'h10, '0, '0, 128'hC000_0000);
    exit_be   = 8'(rand_bits(8));
    exit_data = {rand_bits(32), rand_bits(32)};
    exit_exp  = 64'(merge_bytes('0, 128'(exit_data), 16'(exit_be)));
    single(1'b1, `SOC_CTRL_BASE, 16'(exit_be), 128'(exit_data), '0);
    check_value("exit_o", 128'(exit_exp), 128'(exit_o));
    single(1'b0, `SOC_CTRL_BASE, '0, '0, 128'(exit_exp));

    // UART writes and reads, then an L2 read in order
    uart_access(1'b1, 2'(rand_bits(2)));
    uart_access(1'b1, 2'(rand_bits(2)));
    uart_access(1'b0, 2'(rand_bits(2)));
    single(1'b0, `SOC_DRAM_BASE + {18'd0, idx_list[0], 4'd0}, '0, '0, l2_model[idx_list[0]]);
    uart_access(1'b0, 2'(rand_bits(2)));

    // Unmapped window, its index bits alias L2 word 0
    fill = rand_wide();
    single(1'b1, `SOC_DRAM_BASE, 16'hffff, fill, '0);
    l2_model[0] = fill;
    single(1'b1, 32'h4000_0000, 16'hffff, rand_wide(), '0);
    single(1'b0, 32'h4000_0000, '0, '0, '0);
    single(1'b0, `SOC_DRAM_BASE, '0, '0, l2_model[0]);

    repeat (2) @(negedge clk_i);
    $display("Errors: value=%0d protocol=%0d", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+hdl
hdl/soc_pkg.sv
hdl/addr_router.sv
hdl/l2_lane_bank.sv
hdl/uart_apb_bridge.sv
hdl/ctrl_regs.sv
hdl/resp_merge.sv
hdl/vec_soc.sv
dv/tb_vec_soc.sv

// File: Makefile
.PHONY: compile run clean

BIN = obj_dir/Vtb_vec_soc

compile: $(BIN)

$(BIN): sim.f hdl/*.sv hdl/*.svh dv/*.sv
	verilator --binary --timing --assert -f sim.f --top-module tb_vec_soc -Mdir obj_dir

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
